/* hdl/env_fsm.sv */
// adsr envelope generator
// linear rates, stepped once per envelope tick
// att is an attenuation: 0 is full scale, att_max is silence
`timescale 1ns/1ps

module env_fsm
    import opl_synth_pkg::*;
(
    input  logic             clk125,
    input  logic             arst_n,
    input  logic             env_tick,
    voice_cfg_if.gen_side    cfg,
    output logic [att_w-1:0] att,
    output logic             voice_busy
);

    env_state_t       state;
    logic             kon_prev;    // key-on seen at the previous env tick
    logic [att_w-1:0] atk_step;    // ar * 8
    logic [att_w-1:0] sus_lvl;     // sl * 32
    logic [4:0]       rise_step;   // dr in decay, rr * 2 in release
    logic [att_w:0]   att_up;      // spare msb catches the overshoot

    assign atk_step  = att_w'({cfg.ar, 3'b000});
    assign sus_lvl   = att_w'({cfg.sl, 5'b00000});
    assign rise_step = (state == env_release) ? {cfg.rr, 1'b0} : {1'b0, cfg.dr};
    assign att_up    = {1'b0, att} + (att_w + 1)'(rise_step);

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            state    <= env_off;
            att      <= att_max;
            kon_prev <= 1'b0;
        end else if (env_tick) begin
            kon_prev <= cfg.kon;
            case (state)
                env_off: begin
                    if (cfg.kon && !kon_prev) begin
                        state <= env_attack;            // key-on edge
                    end
                end
                env_attack: begin
                    if (!cfg.kon) begin
                        state <= env_release;
                    end else if (att <= atk_step) begin
                        att   <= '0;                    // peak
                        state <= env_decay;
                    end else begin
                        att <= att - atk_step;
                    end
                end
                env_decay: begin
                    if (!cfg.kon) begin
                        state <= env_release;
                    end else if (att_up >= {1'b0, sus_lvl}) begin
                        att   <= sus_lvl;               // clamp onto the sustain level
                        state <= env_sustain;
                    end else begin
                        att <= att_up[att_w-1:0];
                    end
                end
                env_sustain: begin
                    if (!cfg.kon) begin
                        state <= env_release;           // level holds until then
                    end
                end
                env_release: begin
                    if (cfg.kon) begin
                        state <= env_attack;            // re-trigger from current att
                    end else if (att_up >= {1'b0, att_max}) begin
                        att   <= att_max;
                        state <= env_off;
                    end else begin
                        att <= att_up[att_w-1:0];
                    end
                end
                default: state <= env_off;
            endcase
        end
    end

    assign voice_busy = (state != env_off);

endmodule

/* hdl/fm_voice_top.sv */
// single fm voice
// host register port in, one signed 16-bit sample out per 32 clk125 cycles
`timescale 1ns/1ps

module fm_voice_top
    import opl_reg_pkg::*, opl_synth_pkg::*;
(
    input  logic                       clk125,
    input  logic                       arst_n,
    input  logic                       reg_req,
    input  logic [reg_addr_w-1:0]      reg_addr,
    input  logic [reg_data_w-1:0]      reg_data,
    output logic                       reg_ack,
    output logic signed [sample_w-1:0] sample_out,
    output logic                       sample_valid,
    output logic                       voice_busy
);

    voice_cfg_if cfg_bus ();

    logic               sample_tick;
    logic               env_tick;
    logic [phase_w-1:0] phase;
    logic [att_w-1:0]   att;

    opl_reg_file u_reg_file (
        .clk125   (clk125),
        .arst_n   (arst_n),
        .reg_req  (reg_req),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .reg_ack  (reg_ack),
        .cfg      (cfg_bus)
    );

    sample_timer u_timer (
        .clk125      (clk125),
        .arst_n      (arst_n),
        .sample_tick (sample_tick),
        .env_tick    (env_tick)
    );

    env_fsm u_env (
        .clk125     (clk125),
        .arst_n     (arst_n),
        .env_tick   (env_tick),
        .cfg        (cfg_bus),
        .att        (att),
        .voice_busy (voice_busy)
    );

    phase_gen u_phase (
        .clk125      (clk125),
        .arst_n      (arst_n),
        .sample_tick (sample_tick),
        .cfg         (cfg_bus),
        .phase       (phase)
    );

    operator_out u_op (
        .clk125       (clk125),
        .arst_n       (arst_n),
        .sample_tick  (sample_tick),
        .phase        (phase),
        .att          (att),
        .cfg          (cfg_bus),
        .sample_out   (sample_out),
        .sample_valid (sample_valid)
    );

endmodule

/* hdl/operator_out.sv */
// operator output stage
// quarter-sine lookup, scaled by the clamped envelope plus total level
// sample registered the cycle after the phase and envelope step
`timescale 1ns/1ps

module operator_out
    import opl_synth_pkg::*;
(
    input  logic                       clk125,
    input  logic                       arst_n,
    input  logic                       sample_tick,
    input  logic [phase_w-1:0]         phase,
    input  logic [att_w-1:0]           att,
    voice_cfg_if.gen_side              cfg,
    output logic signed [sample_w-1:0] sample_out,
    output logic                       sample_valid
);

    `include "sine_table.svh"

    logic [att_w:0]             att_sum;     // envelope + tl, before the clamp
    logic [att_w-1:0]           att_tot;
    logic [att_w-1:0]           gain;        // 511 loud down to 0 silent
    logic [1:0]                 quad;
    logic [sine_idx_w-1:0]      idx;
    logic [sine_w-1:0]          mag;
    logic [sine_w+att_w-1:0]    prod;
    logic [sine_w-1:0]          scaled;
    logic signed [sample_w-1:0] sample_nxt;
    logic                       tick_d;      // phase and att are fresh here

    assign att_sum = {1'b0, att} + (att_w + 1)'({cfg.tl, 4'b0000});   // tl * 16
    assign att_tot = (att_sum > {1'b0, att_max}) ? att_max : att_sum[att_w-1:0];
    assign gain    = att_max - att_tot;

    assign quad   = phase[phase_w-1 -: 2];
    assign idx    = quad[0] ? ~phase[phase_w-3 -: sine_idx_w]    // falling quarters mirror
                            : phase[phase_w-3 -: sine_idx_w];
    assign mag    = sine_rom[idx];
    assign prod   = mag * gain;
    assign scaled = prod[att_w +: sine_w];                       // >> 9

    assign sample_nxt = quad[1] ? -$signed({1'b0, scaled})       // negative half wave
                                : $signed({1'b0, scaled});

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            tick_d       <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            tick_d       <= sample_tick;
            sample_valid <= tick_d;      // lines up with sample_out
        end
    end

    always_ff @(posedge clk125) begin
        if (tick_d) begin
            sample_out <= sample_nxt;
        end
    end

endmodule

/* hdl/opl_reg_file.sv */
// voice register file
// four-phase req/ack slave taking one byte per transfer, write only
// unknown addresses complete the handshake and change nothing
`timescale 1ns/1ps

module opl_reg_file
    import opl_reg_pkg::*;
(
    input  logic                  clk125,
    input  logic                  arst_n,
    input  logic                  reg_req,
    input  logic [reg_addr_w-1:0] reg_addr,
    input  logic [reg_data_w-1:0] reg_data,
    output logic                  reg_ack,
    voice_cfg_if.reg_side         cfg
);

    typedef enum logic {
        hs_idle,    // waiting for req
        hs_hold     // byte taken, ack held until req drops
    } hs_state_t;

    hs_state_t hs_state;
    reg_byte_u wr_byte;
    logic      wr_en;

    assign wr_byte = reg_data;
    assign wr_en   = (hs_state == hs_idle) && reg_req;  // one store per request
    assign reg_ack = (hs_state == hs_hold);

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            hs_state <= hs_idle;
        end else begin
            case (hs_state)
                hs_idle: begin
                    if (reg_req) begin
                        hs_state <= hs_hold;    // ack rises with the store
                    end
                end
                hs_hold: begin
                    if (!reg_req) begin
                        hs_state <= hs_idle;    // ack falls once req seen low
                    end
                end
                default: hs_state <= hs_idle;
            endcase
        end
    end

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            cfg.fnum  <= '0;
            cfg.block <= '0;
            cfg.mult  <= '0;
            cfg.kon   <= 1'b0;
            cfg.ar    <= '0;
            cfg.dr    <= '0;
            cfg.sl    <= '0;
            cfg.rr    <= '0;
            cfg.tl    <= '0;
        end else if (wr_en) begin
            case (reg_addr)
                addr_fnum_lo: begin
                    cfg.fnum[7:0] <= reg_data;
                end
                addr_freq_ctl: begin
                    cfg.kon              <= wr_byte.freq.kon;
                    cfg.block            <= wr_byte.freq.block;
                    cfg.fnum[fnum_w-1:8] <= wr_byte.freq.fnum_hi;
                end
                addr_ar_dr: begin
                    cfg.ar <= wr_byte.nib.hi;
                    cfg.dr <= wr_byte.nib.lo;
                end
                addr_sl_rr: begin
                    cfg.sl <= wr_byte.nib.hi;
                    cfg.rr <= wr_byte.nib.lo;
                end
                addr_tl_mult: begin
                    cfg.tl   <= wr_byte.nib.hi;
                    cfg.mult <= wr_byte.nib.lo;
                end
                default: ;                      // acked, dropped
            endcase
        end
    end

endmodule

/* hdl/opl_reg_pkg.sv */
// register map of the fm voice
// host port widths, register addresses and the two layouts of a written byte
package opl_reg_pkg;

    localparam int reg_addr_w = 8;    // host address bus
    localparam int reg_data_w = 8;    // host data bus

    localparam int fnum_w  = 10;
    localparam int block_w = 3;
    localparam int rate_w  = 4;       // every nibble wide field

    localparam logic [reg_addr_w-1:0] addr_fnum_lo  = 8'h00;  // fnum[7:0]
    localparam logic [reg_addr_w-1:0] addr_freq_ctl = 8'h01;  // kon, block, fnum[9:8]
    localparam logic [reg_addr_w-1:0] addr_ar_dr    = 8'h02;
    localparam logic [reg_addr_w-1:0] addr_sl_rr    = 8'h03;
    localparam logic [reg_addr_w-1:0] addr_tl_mult  = 8'h04;

    typedef struct packed {
        logic [rate_w-1:0] hi;
        logic [rate_w-1:0] lo;
    } nibble_pair_t;

    typedef struct packed {
        logic               kon;      // bit 7
        logic [block_w-1:0] block;    // bits 6..4
        logic [1:0]         rsvd;     // bits 3..2, dropped
        logic [fnum_w-9:0]  fnum_hi;  // bits 1..0
    } freq_ctl_t;

    // same byte, decoded by address
    typedef union packed {
        nibble_pair_t nib;
        freq_ctl_t    freq;
    } reg_byte_u;

endpackage

/* hdl/opl_synth_pkg.sv */
// synthesis constants of the fm voice
// tick dividers, datapath widths and the envelope states
package opl_synth_pkg;

    localparam int sample_div = 32;   // clk125 cycles per sample tick
    localparam int env_div    = 4;    // sample ticks per envelope tick
    localparam int cyc_cnt_w  = $clog2(sample_div);
    localparam int env_cnt_w  = $clog2(env_div);

    localparam int phase_w    = 20;   // top 8 bits give quadrant and table index
    localparam int sine_idx_w = 6;    // quarter wave of 64 entries
    localparam int sine_w     = 15;   // table magnitude
    localparam int sample_w   = 16;   // signed output sample

    localparam int att_w = 9;
    localparam logic [att_w-1:0] att_max = '1;  // 511, silence

    // adsr phases of one voice
    typedef enum logic [2:0] {
        env_off,
        env_attack,
        env_decay,
        env_sustain,
        env_release
    } env_state_t;

endpackage

/* hdl/phase_gen.sv */
// phase accumulator
// advances by (fnum * (mult + 1)) << block on every sample tick, wraps at 2^20
`timescale 1ns/1ps

module phase_gen
    import opl_synth_pkg::*;
(
    input  logic               clk125,
    input  logic               arst_n,
    input  logic               sample_tick,
    voice_cfg_if.gen_side      cfg,
    output logic [phase_w-1:0] phase
);

    logic [phase_w-1:0] fnum_ext;
    logic [phase_w-1:0] mult_fac;   // mult 0 still plays the base pitch
    logic [phase_w-1:0] step;

    assign fnum_ext = phase_w'(cfg.fnum);
    assign mult_fac = phase_w'(cfg.mult) + 1'b1;

    // high block values overflow the step, same result mod 2^20
    assign step = (fnum_ext * mult_fac) << cfg.block;

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            phase <= '0;
        end else if (sample_tick) begin
            phase <= phase + step;   // free running wrap
        end
    end

endmodule

/* hdl/sample_timer.sv */
// sample and envelope strobes
// sample_tick is sampled every 32nd edge, env_tick on every fourth of those
`timescale 1ns/1ps

module sample_timer
    import opl_synth_pkg::*;
(
    input  logic clk125,
    input  logic arst_n,
    output logic sample_tick,
    output logic env_tick
);

    logic [cyc_cnt_w-1:0] cyc_cnt;    // clk125 cycles within one sample
    logic [env_cnt_w-1:0] tick_cnt;   // samples within one envelope step

    assign sample_tick = (cyc_cnt == cyc_cnt_w'(sample_div - 1));
    assign env_tick    = sample_tick && (tick_cnt == env_cnt_w'(env_div - 1));

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            cyc_cnt  <= '0;
            tick_cnt <= '0;
        end else begin
            if (sample_tick) begin
                cyc_cnt <= '0;
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
            if (env_tick) begin
                tick_cnt <= '0;
            end else if (sample_tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

endmodule

/* hdl/sine_table.svh */
// quarter-wave sine table, 64 points from 0 to pi/2
// each point sits mid step: round(32767 * sin((i + 0.5) * pi / 128))
localparam logic [sine_w-1:0] sine_rom [0:(2**sine_idx_w)-1] = '{
    15'd402,   15'd1206,  15'd2009,  15'd2811,
    15'd3612,  15'd4410,  15'd5205,  15'd5998,
    15'd6786,  15'd7571,  15'd8351,  15'd9126,
    15'd9896,  15'd10659, 15'd11417, 15'd12167,
    15'd12910, 15'd13645, 15'd14372, 15'd15090,
    15'd15800, 15'd16499, 15'd17189, 15'd17869,
    15'd18537, 15'd19195, 15'd19841, 15'd20475,
    15'd21096, 15'd21705, 15'd22301, 15'd22884,
    15'd23452, 15'd24007, 15'd24547, 15'd25072,
    15'd25582, 15'd26077, 15'd26556, 15'd27019,
    15'd27466, 15'd27896, 15'd28310, 15'd28706,
    15'd29085, 15'd29447, 15'd29791, 15'd30117,
    15'd30424, 15'd30714, 15'd30985, 15'd31237,
    15'd31470, 15'd31685, 15'd31880, 15'd32057,
    15'd32213, 15'd32351, 15'd32469, 15'd32567,
    15'd32646, 15'd32705, 15'd32745, 15'd32765
};

/* hdl/voice_cfg_if.sv */
// voice settings bus
// written by the register file, read by phase, envelope and output stages
`timescale 1ns/1ps

interface voice_cfg_if
    import opl_reg_pkg::*;
();

    logic [fnum_w-1:0]  fnum;
    logic [block_w-1:0] block;   // octave shift
    logic [rate_w-1:0]  mult;    // frequency multiple minus one
    logic               kon;     // key-on level
    logic [rate_w-1:0]  ar;      // attack rate
    logic [rate_w-1:0]  dr;      // decay rate
    logic [rate_w-1:0]  sl;      // sustain level, steps of 32
    logic [rate_w-1:0]  rr;      // release rate
    logic [rate_w-1:0]  tl;      // total level, steps of 16

    modport reg_side (
        output fnum, block, mult, kon, ar, dr, sl, rr, tl
    );

    modport gen_side (
        input fnum, block, mult, kon, ar, dr, sl, rr, tl
    );

endinterface

/* list.f */
+incdir+hdl
hdl/opl_reg_pkg.sv
hdl/opl_synth_pkg.sv
hdl/voice_cfg_if.sv
hdl/opl_reg_file.sv
hdl/sample_timer.sv
hdl/env_fsm.sv
hdl/phase_gen.sv
hdl/operator_out.sv
hdl/fm_voice_top.sv
sim/fm_voice_sva.sv
sim/fm_voice_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the fm voice testbench with verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module fm_voice_tb -o fm_voice_sim > build.log 2>&1 \
    && ./obj_dir/fm_voice_sim > sim.log 2>&1 \
    || echo "build or simulation ended with an error, see build.log and sim.log"

[ -f sim.log ] && cat sim.log
grep -q 'All tests passed!' sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

/* sim/fm_voice_sva.sv */
// protocol and envelope checks for the fm voice
// bound once into the register file and once into the envelope generator
`timescale 1ns/1ps

module fm_voice_sva
    import opl_synth_pkg::*;
(
    input logic             clk125,
    input logic             arst_n,
    input logic             reg_req,
    input logic             reg_ack,
    input logic [2:0]       state,    // env_state_t encoding
    input logic [att_w-1:0] att,
    input logic [3:0]       sl
);

    // ack only answers a pending request
    ack_needs_req: assert property (
        @(posedge clk125) disable iff (!arst_n)
        $rose(reg_ack) |-> $past(reg_req)
    ) else $error("reg_ack rose without reg_req");

    ack_release: assert property (
        @(posedge clk125) disable iff (!arst_n)
        $fell(reg_req) |-> ##[0:2] !reg_ack
    ) else $error("reg_ack still high two cycles after reg_req fell");

    sustain_level: assert property (
        @(posedge clk125) disable iff (!arst_n)
        (state == env_sustain) |-> (att == att_w'({sl, 5'b00000}))
    ) else $error("sustain attenuation is not sl * 32");

endmodule

// handshake side, envelope inputs tied to an idle voice
bind opl_reg_file fm_voice_sva reg_file_sva (
    .clk125  (clk125),
    .arst_n  (arst_n),
    .reg_req (reg_req),
    .reg_ack (reg_ack),
    .state   (3'd0),
    .att     ('0),
    .sl      (4'd0)
);

// envelope side, host port held quiet
bind env_fsm fm_voice_sva env_sva (
    .clk125  (clk125),
    .arst_n  (arst_n),
    .reg_req (1'b0),
    .reg_ack (1'b0),
    .state   (state),
    .att     (att),
    .sl      (cfg.sl)
);

/* sim/fm_voice_tb.sv */
// testbench for the single fm voice
// writes voice settings from a table, checks every sample against a reference model
`timescale 1ns/1ps

module fm_voice_tb
    import opl_reg_pkg::*, opl_synth_pkg::*;
();

    `include "sine_table.svh"

    localparam int timeout_cyc = 64;   // two sample periods
    localparam int st_off      = 0;
    localparam int st_attack   = 1;
    localparam int st_decay    = 2;
    localparam int st_sustain  = 3;
    localparam int st_release  = 4;

    typedef struct {
        logic [7:0] fnum_lo;
        logic [7:0] freq_ctl;   // kon set
        logic [7:0] ar_dr;
        logic [7:0] sl_rr;
        logic [7:0] tl_mult;
        int         n_on;       // samples with key held
        int         n_off;      // samples after key-off
        logic       busy_end;
    } row_t;

    logic               clk125 = 1'b0;
    logic               arst_n;
    logic               reg_req;
    logic [7:0]         reg_addr;
    logic [7:0]         reg_data;
    logic               reg_ack;
    logic signed [15:0] sample_out;
    logic               sample_valid;
    logic               voice_busy;
    row_t               rows [4];
    int                 cyc = 0;        // edges since reset release
    int                 last_cyc = 1;   // first sample due on cycle 33

    // model of the voice settings and generators
    int m_fnum     = 0;
    int m_block    = 0;
    int m_mult     = 0;
    int m_kon      = 0;
    int m_ar       = 0;
    int m_dr       = 0;
    int m_sl       = 0;
    int m_rr       = 0;
    int m_tl       = 0;
    int m_phase    = 0;
    int m_att      = 511;
    int m_state    = st_off;
    int m_kon_prev = 0;
    int m_tick     = 0;

    fm_voice_top uut (
        .clk125       (clk125),
        .arst_n       (arst_n),
        .reg_req      (reg_req),
        .reg_addr     (reg_addr),
        .reg_data     (reg_data),
        .reg_ack      (reg_ack),
        .sample_out   (sample_out),
        .sample_valid (sample_valid),
        .voice_busy   (voice_busy)
    );

    always #5 clk125 = ~clk125;

    always @(posedge clk125) begin
        if (arst_n) cyc <= cyc + 1;
    end

    task automatic report_failure();
        $display("Test failures found");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        report_failure();
    endtask

    task automatic compare(input logic signed [31:0] got, input logic signed [31:0] exp,
                           input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
            report_failure();
        end
    endtask

    // shadow of the register map, applied once the byte is stored
    task automatic track_write(input logic [7:0] addr, input logic [7:0] data);
        case (addr)
            addr_fnum_lo: m_fnum = (m_fnum & 'h300) | int'(data);
            addr_freq_ctl: begin
                m_kon   = int'(data[7]);
                m_block = int'(data[6:4]);
                m_fnum  = (m_fnum & 'hff) | int'({data[1:0], 8'h00});
            end
            addr_ar_dr: begin
                m_ar = int'(data[7:4]);
                m_dr = int'(data[3:0]);
            end
            addr_sl_rr: begin
                m_sl = int'(data[7:4]);
                m_rr = int'(data[3:0]);
            end
            addr_tl_mult: begin
                m_tl   = int'(data[7:4]);
                m_mult = int'(data[3:0]);
            end
            default: ;   // unmapped, no effect
        endcase
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        int n;
        compare(reg_ack, 0, "reg_ack low before request");
        @(posedge clk125);
        reg_addr <= addr;
        reg_data <= data;
        reg_req  <= 1'b1;
        n = 0;
        do begin
            @(negedge clk125);
            n++;
            if (n > timeout_cyc) abort_on_timeout("reg_ack to rise");
        end while (!reg_ack);
        @(posedge clk125);
        reg_req <= 1'b0;   // ack must drop after this
        n = 0;
        do begin
            @(negedge clk125);
            n++;
            if (n > timeout_cyc) abort_on_timeout("reg_ack to fall");
        end while (reg_ack);
        track_write(addr, data);
    endtask

    // linear adsr, one step per envelope tick
    task automatic env_step();
        case (m_state)
            st_off: if (m_kon == 1 && m_kon_prev == 0) m_state = st_attack;
            st_attack: begin
                if (m_kon == 0) m_state = st_release;
                else if (m_att <= m_ar * 8) begin
                    m_att   = 0;
                    m_state = st_decay;
                end else m_att = m_att - m_ar * 8;
            end
            st_decay: begin
                if (m_kon == 0) m_state = st_release;
                else if (m_att + m_dr >= m_sl * 32) begin
                    m_att   = m_sl * 32;
                    m_state = st_sustain;
                end else m_att = m_att + m_dr;
            end
            st_sustain: if (m_kon == 0) m_state = st_release;
            default: begin
                if (m_kon == 1) m_state = st_attack;   // re-trigger keeps att
                else if (m_att + m_rr * 2 >= 511) begin
                    m_att   = 511;
                    m_state = st_off;
                end else m_att = m_att + m_rr * 2;
            end
        endcase
        m_kon_prev = m_kon;
    endtask

    task automatic model_step(output int exp_sample);
        int tot;
        int quad;
        int idx;
        m_phase = (m_phase + ((m_fnum * (m_mult + 1)) << m_block)) & 'hfffff;
        m_tick  = m_tick + 1;
        if (m_tick == env_div) begin
            m_tick = 0;
            env_step();
        end
        tot  = (m_att + m_tl * 16 > 511) ? 511 : m_att + m_tl * 16;
        quad = m_phase >> 18;
        idx  = (m_phase >> 12) & 63;
        if (quad % 2 == 1) idx = 63 - idx;             // mirrored quarter
        exp_sample = (int'(sine_rom[idx]) * (511 - tot)) >> 9;
        if (quad >= 2) exp_sample = -exp_sample;       // lower half wave
    endtask

    task automatic next_sample();
        int n;
        int exp_sample;
        n = 0;
        do begin
            @(negedge clk125);
            n++;
            if (n > timeout_cyc) abort_on_timeout("sample_valid");
        end while (!sample_valid);
        compare(cyc - last_cyc, sample_div, "cycles between samples");
        last_cyc = cyc;
        model_step(exp_sample);
        compare(sample_out, exp_sample, "sample_out");
        compare(voice_busy, m_state != st_off, "voice_busy");
    endtask

    initial begin
        arst_n   = 1'b0;
        reg_req  = 1'b0;
        reg_addr = '0;
        reg_data = '0;
        // fnum_lo, freq_ctl, ar_dr, sl_rr, tl_mult, n_on, n_off, busy at end
        rows[0] = '{8'h55, 8'hA1, 8'hF4, 8'h48, 8'h11, 200, 40, 1'b1};   // ends in release
        rows[1] = '{8'hFF, 8'h83, 8'hCF, 8'h2F, 8'h03, 120, 140, 1'b0};  // re-trigger, then off
        rows[2] = '{8'hA3, 8'hD1, 8'hF2, 8'h14, 8'h32, 80, 200, 1'b1};   // fast phase, key-off in decay
        rows[3] = '{8'hC0, 8'hB2, 8'h81, 8'hFF, 8'hF5, 60, 80, 1'b0};    // heavy tl clamps
        repeat (2) @(posedge clk125);
        arst_n <= 1'b1;
        next_sample();   // idle voice is silent
        for (int r = 0; r < 4; r++) begin
            // burst fits between two sample ticks
            write_reg(addr_fnum_lo, rows[r].fnum_lo);
            write_reg(addr_freq_ctl, rows[r].freq_ctl);
            write_reg(addr_ar_dr, rows[r].ar_dr);
            write_reg(addr_sl_rr, rows[r].sl_rr);
            write_reg(addr_tl_mult, rows[r].tl_mult);
            write_reg(8'h05, 8'hFF);   // unmapped
            repeat (rows[r].n_on) next_sample();
            write_reg(addr_freq_ctl, rows[r].freq_ctl & 8'h7F);
            repeat (rows[r].n_off) next_sample();
            compare(voice_busy, rows[r].busy_end, "voice_busy at end of row");
        end
        $display("All tests passed!");
        $finish;
    end

endmodule
